/* Bender.yml */
package:
  name: cpuTop

sources:
  - cpuPkg.sv
  - memBusIf.sv
  - pipeReg.sv
  - fetchStage.sv
  - decodeStage.sv
  - idexReg.sv
  - executeStage.sv
  - memWbStage.sv
  - memArbiter.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuTop_properties.sv
      - cpuTb.sv

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs      = 8;
    localparam int opcodeWidth  = 5;
    localparam int functWidth   = 2;
    localparam int immWidth     = 5;   // Bits 4 to 0.
    localparam int jumpWidth    = 11;  // Bits 10 to 0.

    localparam int opMsb = 15;
    localparam int opLsb = 11;
    localparam int rsMsb = 10;
    localparam int rsLsb = 8;
    localparam int rtMsb = 7;
    localparam int rtLsb = 5;
    localparam int rdMsb = 4;
    localparam int rdLsb = 2;

    // An all-zero word decodes as NOP.
    typedef enum logic [opcodeWidth-1:0] {
        opArith = 5'h01,
        opAddi  = 5'h02,
        opLd    = 5'h03,
        opSt    = 5'h04,
        opBeqz  = 5'h05,
        opJ     = 5'h06,
        opHalt  = 5'h07,
        opNop   = 5'h00
    } opcodeT;

    typedef logic [opcodeWidth-1:0] aluOpT;

    typedef enum logic [functWidth-1:0] {
        fnAdd = 2'b00,
        fnSub = 2'b01,
        fnAnd = 2'b10,
        fnXor = 2'b11
    } functT;

    typedef struct packed {
        logic aluSrc;
        logic branch;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic jump;
        logic halt;
    } ctrlT;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
        logic                 valid;
    } ifIdT;

    typedef struct packed {
        logic [dataWidth-1:0]    aluResult;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] writeReg;
        logic                    writeRegValid;
        logic                    memRead;
        logic                    memWrite;
        logic                    memToReg;
        logic                    regWrite;
        logic                    halt;
    } exMemT;

endpackage

`default_nettype wire

/* cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int numTests  = 5;
    localparam int maxCycles = 2000;
    localparam int memWords  = 256;

    logic                 clk;
    logic                 rstN;
    logic                 memEn;
    logic                 memWe;
    logic                 halt;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWdata;
    logic [dataWidth-1:0] memRdata;

    logic [dataWidth-1:0] mem [memWords];
    logic [dataWidth-1:0] refMem [memWords];
    logic [dataWidth-1:0] prog [$];
    logic [dataWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    integer               seed;
    int                   storeIdx;
    int                   testErrors;
    int                   passCount;
    int                   failCount;

    cpuTop u_dut (
        .clk, .rstN, .memEn, .memAddr, .memWdata, .memWe, .memRdata, .halt
    );

    always #5 clk = ~clk;

    // Unknown address reads zero.
    assign memRdata = $isunknown(memAddr) ? '0 : mem[memAddr[7:0]];

    always @(posedge clk) begin
        if (memEn && memWe) begin
            mem[memAddr[7:0]] <= memWdata;
        end
    end

    always @(posedge clk) begin
        if (rstN && memEn && memWe) begin
            assert (storeIdx < expAddr.size()) else begin
                $display("store to %h at %0t was not expected by the reference", memAddr, $time);
                testErrors++;
            end
            if (storeIdx < expAddr.size()) begin
                assert (memAddr == expAddr[storeIdx]) else begin
                    $display("error t=%0t memAddr got %h expected %h",
                             $time, memAddr, expAddr[storeIdx]);
                    testErrors++;
                end
                assert (memWdata == expData[storeIdx]) else begin
                    $display("error t=%0t memWdata got %h expected %h",
                             $time, memWdata, expData[storeIdx]);
                    testErrors++;
                end
            end
            storeIdx++;
        end
    end

    function automatic logic [15:0] fillWord(input int a);
        return {a[7:0], ~a[7:0]} ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] encR(input logic [1:0] f, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [2:0] rt);
        return {opArith, rs, rt, rd, f};
    endfunction

    function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rt,
                                         input logic [2:0] rs, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] encJ(input logic [10:0] disp);
        return {opJ, disp};
    endfunction

    // ISA-level model, regs start at zero.
    function automatic void interpret();
        logic [15:0] regs [8];
        logic [15:0] pc;
        logic [15:0] instr;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] ea;
        int          steps;
        bit          done;
        refMem = mem;
        expAddr.delete();
        expData.delete();
        foreach (regs[i]) regs[i] = '0;
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 1000) begin
            instr = refMem[pc[7:0]];
            a     = regs[instr[10:8]];
            b     = regs[instr[7:5]];
            imm   = {{11{instr[4]}}, instr[4:0]};
            ea    = a + imm;
            pc    = pc + 1'b1;
            case (instr[15:11])
                opArith: begin
                    case (instr[1:0])
                        fnAdd: regs[instr[4:2]] = a + b;
                        fnSub: regs[instr[4:2]] = a - b;
                        fnAnd: regs[instr[4:2]] = a & b;
                        default: regs[instr[4:2]] = a ^ b;
                    endcase
                end
                opAddi: regs[instr[7:5]] = ea;
                opLd:   regs[instr[7:5]] = refMem[ea[7:0]];
                opSt: begin
                    refMem[ea[7:0]] = b;
                    expAddr.push_back(ea);
                    expData.push_back(b);
                end
                opBeqz: if (a == '0) pc = pc + imm;
                opJ:    pc = pc + {{5{instr[10]}}, instr[10:0]};
                opHalt: done = 1'b1;
                default: ;  // NOP and unused codes.
            endcase
            steps++;
        end
    endfunction

    function automatic void addPrologue();
        int i;
        prog.delete();
        for (i = 0; i < numRegs; i++) begin
            prog.push_back(encR(fnXor, 3'(i), 3'(i), 3'(i)));  // Clears a leftover value.
        end
        for (i = 0; i < numRegs; i++) begin
            prog.push_back(encI(opLd, 3'(i), 3'(i), 5'h1f));  // Zero word at 255.
        end
        prog.push_back(encI(opLd, 3'd7, 3'd0, 5'h1e));  // r7 = 0x80, store base.
    endfunction

    function automatic void buildArith();
        addPrologue();
        prog.push_back(encI(opAddi, 3'd1, 3'd0, 5));
        prog.push_back(encI(opAddi, 3'd2, 3'd1, -3));
        prog.push_back(encR(fnAdd, 3'd3, 3'd1, 3'd2));
        prog.push_back(encR(fnSub, 3'd4, 3'd3, 3'd1));
        prog.push_back(encR(fnAnd, 3'd5, 3'd3, 3'd1));
        prog.push_back(encR(fnXor, 3'd6, 3'd5, 3'd4));
        prog.push_back(encI(opSt, 3'd3, 3'd7, 0));
        prog.push_back(encI(opSt, 3'd4, 3'd7, 1));
        prog.push_back(encI(opSt, 3'd5, 3'd7, 2));
        prog.push_back(encI(opSt, 3'd6, 3'd7, 3));
        prog.push_back(encR(fnAdd, 3'd0, 3'd6, 3'd6));
        prog.push_back(encI(opSt, 3'd0, 3'd7, 4));
        prog.push_back(encI(opAddi, 3'd1, 3'd1, 15));
        prog.push_back(encR(fnSub, 3'd2, 3'd0, 3'd1));
        prog.push_back(encI(opSt, 3'd2, 3'd7, 5));
        prog.push_back({opHalt, 11'h0});
    endfunction

    function automatic void buildLoadStore();
        addPrologue();
        prog.push_back(encI(opAddi, 3'd1, 3'd0, 11));
        prog.push_back(encI(opSt, 3'd1, 3'd7, 5));
        prog.push_back(encI(opLd, 3'd2, 3'd7, 5));
        prog.push_back(encI(opAddi, 3'd2, 3'd2, -2));
        prog.push_back(encI(opSt, 3'd2, 3'd7, -3));
        prog.push_back(encI(opLd, 3'd3, 3'd7, -3));
        prog.push_back(encI(opLd, 3'd4, 3'd7, -16));
        prog.push_back(encR(fnXor, 3'd5, 3'd3, 3'd4));
        prog.push_back(encI(opSt, 3'd5, 3'd7, 15));
        prog.push_back(encI(opLd, 3'd6, 3'd0, 1));  // Reads a program word.
        prog.push_back(encI(opSt, 3'd6, 3'd7, 6));
        prog.push_back({opHalt, 11'h0});
    endfunction

    function automatic void buildBranches();
        addPrologue();
        prog.push_back(encI(opAddi, 3'd1, 3'd0, 0));
        prog.push_back(encI(opBeqz, 3'd0, 3'd1, 1));
        prog.push_back(encI(opSt, 3'd1, 3'd7, 0));
        prog.push_back(encI(opAddi, 3'd2, 3'd0, 3));
        prog.push_back(encI(opBeqz, 3'd0, 3'd2, 1));
        prog.push_back(encI(opSt, 3'd2, 3'd7, 1));
        prog.push_back(encJ(11'd2));
        prog.push_back(encI(opSt, 3'd2, 3'd7, 2));
        prog.push_back(encI(opSt, 3'd2, 3'd7, 3));
        prog.push_back(encI(opSt, 3'd1, 3'd7, 4));
        prog.push_back({opHalt, 11'h0});
    endfunction

    function automatic void buildHalt();
        addPrologue();
        prog.push_back(encI(opAddi, 3'd1, 3'd0, 9));
        prog.push_back(encI(opSt, 3'd1, 3'd7, 0));
        prog.push_back(encI(opAddi, 3'd2, 3'd1, 1));
        prog.push_back(encI(opSt, 3'd2, 3'd7, 1));
        prog.push_back({opHalt, 11'h0});
        prog.push_back(encI(opSt, 3'd1, 3'd7, 2));
        prog.push_back(encI(opAddi, 3'd1, 3'd1, 1));
        prog.push_back(encI(opSt, 3'd1, 3'd7, 3));
        prog.push_back({opHalt, 11'h0});
    endfunction

    function automatic void buildRandom(input int len);
        int          k;
        int          d;
        int          haltIdx;
        logic [31:0] r;
        logic [2:0]  dst;
        addPrologue();
        haltIdx = prog.size() + len;
        for (k = 0; k < len; k++) begin
            r   = $random(seed);
            dst = r[5:3] % 7;  // r7 stays the store base.
            d   = r[20:19];
            if (d > haltIdx - prog.size() - 1) d = haltIdx - prog.size() - 1;
            case (r[2:0])
                3'd0, 3'd1: prog.push_back(encR(r[18:17], dst, r[8:6], r[11:9]));
                3'd2: prog.push_back(encI(opAddi, dst, r[8:6], r[16:12]));
                3'd3: prog.push_back(encI(opLd, dst, r[8:6], r[16:12]));
                3'd4, 3'd5: prog.push_back(encI(opSt, r[11:9], 3'd7, r[16:12]));
                3'd6: prog.push_back(encI(opBeqz, 3'd0, r[8:6], 5'(d)));
                default: prog.push_back(encJ(11'(d)));
            endcase
        end
        prog.push_back({opHalt, 11'h0});
    endfunction

    task automatic runTest(input string name);
        int a;
        @(posedge clk);
        #1 rstN = 1'b0;
        for (a = 0; a < memWords; a++) mem[a] = fillWord(a);
        for (a = 0; a < prog.size(); a++) mem[a] = prog[a];
        mem[254] = 16'h0080;
        mem[255] = '0;
        interpret();
        storeIdx   = 0;
        testErrors = 0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        while (halt !== 1'b1) @(posedge clk);
        repeat (4) begin
            @(posedge clk);
            assert (memEn === 1'b0) else begin
                $display("memory request after halt at %0t", $time);
                testErrors++;
            end
        end
        assert (storeIdx == expAddr.size()) else begin
            $display("%s made %0d stores where %0d were expected", name, storeIdx,
                     expAddr.size());
            testErrors++;
        end
        for (a = 0; a < memWords; a++) begin
            assert (mem[a] === refMem[a]) else begin
                $display("error t=%0t mem[%0d] got %h expected %h", $time, a, mem[a], refMem[a]);
                testErrors++;
            end
        end
        if (testErrors == 0) begin
            passCount++;
            $display("%s: ok, %0d stores checked", name, storeIdx);
        end else begin
            failCount++;
            $display("%s: %0d errors", name, testErrors);
        end
    endtask

    initial begin
        #(numTests * maxCycles * 10);
        $display("timeout: the run did not finish within %0d cycles per test", maxCycles);
        $display("test failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        seed      = 32'h3c28_da6c;
        passCount = 0;
        failCount = 0;
        storeIdx  = 0;
        foreach (mem[i]) mem[i] = fillWord(i);
        buildArith();
        runTest("arith chain");
        buildLoadStore();
        runTest("load store");
        buildBranches();
        runTest("branches");
        buildHalt();
        runTest("halt");
        buildRandom(48);
        runTest("random program");
        $display("tests: %0d ok, %0d failing, %0d property failures", passCount, failCount,
                 u_dut.u_props.propErrors);
        if (failCount == 0 && u_dut.u_props.propErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* cpuTop.f */
cpuPkg.sv
memBusIf.sv
pipeReg.sv
fetchStage.sv
decodeStage.sv
idexReg.sv
executeStage.sv
memWbStage.sv
memArbiter.sv
cpuTop.sv
cpuTop_properties.sv
cpuTb.sv

/* cpuTop.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
    input  logic                         clk,
    input  logic                         rstN,
    output logic                         memEn,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWdata,
    output logic                         memWe,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    output logic                         halt
);
    import cpuPkg::*;

    memBusIf fetchBus ();
    memBusIf dataBus ();

    ifIdT                    ifIdD;
    ifIdT                    ifIdQ;
    exMemT                   exMemD;
    exMemT                   exMemQ;
    logic                    stall;
    logic                    redirect;
    logic [dataWidth-1:0]    target;
    logic                    wbEn;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;

    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    read1;
    logic [dataWidth-1:0]    read2;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    jumpDist;
    functT                   funct;
    aluOpT                   aluOp;
    logic [regAddrWidth-1:0] writeReg;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic                    rsValid;
    logic                    rtValid;
    logic                    writeRegValid;
    ctrlT                    ctrl;

    logic [dataWidth-1:0]    pcEx;
    logic [dataWidth-1:0]    read1Ex;
    logic [dataWidth-1:0]    read2Ex;
    logic [dataWidth-1:0]    immEx;
    logic [dataWidth-1:0]    jumpDistEx;
    functT                   functEx;
    aluOpT                   aluOpEx;
    logic [regAddrWidth-1:0] writeRegEx;
    logic                    writeRegValidEx;
    ctrlT                    ctrlEx;

    fetchStage u_fetch (
        .clk, .rstN, .stall, .redirect, .target,
        .halted (halt),
        .bus    (fetchBus),
        .ifId   (ifIdD)
    );

    pipeReg #(.payloadT(ifIdT)) u_ifIdReg (
        .clk, .rstN,
        .en    (!stall),
        .flush (redirect),
        .d     (ifIdD),
        .q     (ifIdQ)
    );

    decodeStage u_decode (
        .clk, .rstN,
        .ifId             (ifIdQ),
        .wbEn, .wbReg, .wbData,
        .exWriteReg       (writeRegEx),
        .exWriteRegValid  (writeRegValidEx),
        .memWriteReg      (exMemQ.writeReg),
        .memWriteRegValid (exMemQ.writeRegValid),
        .read1, .read2, .imm, .jumpDist, .pc, .funct, .aluOp,
        .writeReg, .rs, .rt, .rsValid, .rtValid, .writeRegValid, .ctrl, .stall
    );

    idexReg u_idex (
        .clk, .rstN,
        .pc, .read1, .read2, .imm, .jumpDist, .funct, .aluOp,
        .writeReg, .rs, .rt, .rsValid, .rtValid, .writeRegValid, .ctrl,
        .controlZeroIdEx1 (stall),
        .controlZeroIdEx2 (redirect),
        .pcEx, .read1Ex, .read2Ex, .immEx, .jumpDistEx, .functEx, .aluOpEx,
        .writeRegEx,
        .rsEx      (),
        .rtEx      (),
        .rsValidEx (),
        .rtValidEx (),
        .writeRegValidEx, .ctrlEx
    );

    executeStage u_execute (
        .pcEx, .read1Ex, .read2Ex, .immEx, .jumpDistEx, .functEx, .aluOpEx,
        .writeRegEx, .writeRegValidEx, .ctrlEx,
        .redirect, .target,
        .exMem (exMemD)
    );

    pipeReg #(.payloadT(exMemT)) u_exMemReg (
        .clk, .rstN,
        .en    (1'b1),
        .flush (1'b0),
        .d     (exMemD),
        .q     (exMemQ)
    );

    memWbStage u_memWb (
        .clk, .rstN,
        .exMem (exMemQ),
        .bus   (dataBus),
        .wbEn, .wbReg, .wbData, .halt
    );

    memArbiter u_arbiter (
        .clk, .rstN, .fetchBus, .dataBus,
        .memEn, .memAddr, .memWdata, .memWe, .memRdata
    );
endmodule

`default_nettype wire

/* cpuTop_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTopProperties (
    input logic         clk,
    input logic         rstN,
    input logic         memEn,
    input logic         memWe,
    input logic         halt,
    input logic         stall,
    input logic         redirect,
    input cpuPkg::ctrlT ctrlEx
);

    int propErrors = 0;

    weNeedsEn: assert property (@(posedge clk) disable iff (!rstN) memWe |-> memEn)
        else begin
            $error("memWe high while memEn is low");
            propErrors++;
        end

    // Halted core stays off the port.
    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halt && $past(halt) |-> !memEn && !memWe)
        else begin
            $error("memory port active after halt");
            propErrors++;
        end

    squashClearsWrites: assert property (@(posedge clk) disable iff (!rstN)
        stall || redirect |=> !ctrlEx.regWrite && !ctrlEx.memWrite)
        else begin
            $error("squashed ID/EX slot kept a write control");
            propErrors++;
        end
endmodule

bind cpuTop cpuTopProperties u_props (
    .clk, .rstN, .memEn, .memWe, .halt, .stall, .redirect, .ctrlEx
);

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  cpuPkg::ifIdT                    ifId,
    input  logic                            wbEn,
    input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
    input  logic [cpuPkg::dataWidth-1:0]    wbData,
    input  logic [cpuPkg::regAddrWidth-1:0] exWriteReg,
    input  logic                            exWriteRegValid,
    input  logic [cpuPkg::regAddrWidth-1:0] memWriteReg,
    input  logic                            memWriteRegValid,
    output logic [cpuPkg::dataWidth-1:0]    read1,
    output logic [cpuPkg::dataWidth-1:0]    read2,
    output logic [cpuPkg::dataWidth-1:0]    imm,
    output logic [cpuPkg::dataWidth-1:0]    jumpDist,
    output logic [cpuPkg::dataWidth-1:0]    pc,
    output cpuPkg::functT                   funct,
    output cpuPkg::aluOpT                   aluOp,
    output logic [cpuPkg::regAddrWidth-1:0] writeReg,
    output logic [cpuPkg::regAddrWidth-1:0] rs,
    output logic [cpuPkg::regAddrWidth-1:0] rt,
    output logic                            rsValid,
    output logic                            rtValid,
    output logic                            writeRegValid,
    output cpuPkg::ctrlT                    ctrl,
    output logic                            stall
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regFile [numRegs];
    opcodeT               op;
    logic                 rsHit;
    logic                 rtHit;

    assign op       = opcodeT'(ifId.instr[opMsb:opLsb]);
    assign aluOp    = ifId.instr[opMsb:opLsb];
    assign rs       = ifId.instr[rsMsb:rsLsb];
    assign rt       = ifId.instr[rtMsb:rtLsb];
    assign funct    = functT'(ifId.instr[functWidth-1:0]);
    assign pc       = ifId.pc;
    assign imm      = {{(dataWidth-immWidth){ifId.instr[immWidth-1]}},
                       ifId.instr[immWidth-1:0]};
    assign jumpDist = {{(dataWidth-jumpWidth){ifId.instr[jumpWidth-1]}},
                       ifId.instr[jumpWidth-1:0]};

    always_ff @(posedge clk) begin
        if (rstN && wbEn) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Write-back bypasses the array in the same cycle.
    assign read1 = (wbEn && wbReg == rs) ? wbData : regFile[rs];
    assign read2 = (wbEn && wbReg == rt) ? wbData : regFile[rt];

    always_comb begin
        ctrl          = '0;
        rsValid       = 1'b0;
        rtValid       = 1'b0;
        writeRegValid = 1'b0;
        writeReg      = ifId.instr[rtMsb:rtLsb];  // I-type destination.
        if (ifId.valid) begin
            case (op)
                opArith: begin
                    rsValid       = 1'b1;
                    rtValid       = 1'b1;
                    writeRegValid = 1'b1;
                    writeReg      = ifId.instr[rdMsb:rdLsb];
                    ctrl.regWrite = 1'b1;
                end
                opAddi: begin
                    rsValid       = 1'b1;
                    writeRegValid = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                opLd: begin
                    rsValid       = 1'b1;
                    writeRegValid = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                opSt: begin
                    rsValid       = 1'b1;
                    rtValid       = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                opBeqz: begin
                    rsValid     = 1'b1;
                    ctrl.branch = 1'b1;
                end
                opJ:     ctrl.jump = 1'b1;
                opHalt:  ctrl.halt = 1'b1;
                default: ctrl      = '0;
            endcase
        end
    end

    assign rsHit = (exWriteRegValid && exWriteReg == rs) ||
                   (memWriteRegValid && memWriteReg == rs);
    assign rtHit = (exWriteRegValid && exWriteReg == rt) ||
                   (memWriteRegValid && memWriteReg == rt);
    assign stall = (rsValid && rsHit) || (rtValid && rtHit);
endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  logic [cpuPkg::dataWidth-1:0]    pcEx,
    input  logic [cpuPkg::dataWidth-1:0]    read1Ex,
    input  logic [cpuPkg::dataWidth-1:0]    read2Ex,
    input  logic [cpuPkg::dataWidth-1:0]    immEx,
    input  logic [cpuPkg::dataWidth-1:0]    jumpDistEx,
    input  cpuPkg::functT                   functEx,
    input  cpuPkg::aluOpT                   aluOpEx,
    input  logic [cpuPkg::regAddrWidth-1:0] writeRegEx,
    input  logic                            writeRegValidEx,
    input  cpuPkg::ctrlT                    ctrlEx,
    output logic                            redirect,
    output logic [cpuPkg::dataWidth-1:0]    target,
    output cpuPkg::exMemT                   exMem
);
    import cpuPkg::*;

    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;

    assign opB = ctrlEx.aluSrc ? immEx : read2Ex;

    // ADDI, LD and ST all add the immediate.
    always_comb begin
        aluResult = read1Ex + opB;
        if (aluOpEx == opArith) begin
            case (functEx)
                fnAdd: aluResult = read1Ex + opB;
                fnSub: aluResult = read1Ex - opB;
                fnAnd: aluResult = read1Ex & opB;
                fnXor: aluResult = read1Ex ^ opB;
            endcase
        end
    end

    assign redirect = (ctrlEx.branch && read1Ex == '0) || ctrlEx.jump;
    assign target   = pcEx + 1'b1 + (ctrlEx.jump ? jumpDistEx : immEx);

    always_comb begin
        exMem.aluResult     = aluResult;
        exMem.storeData     = read2Ex;
        exMem.writeReg      = writeRegEx;
        exMem.writeRegValid = writeRegValidEx;
        exMem.memRead       = ctrlEx.memRead;
        exMem.memWrite      = ctrlEx.memWrite;
        exMem.memToReg      = ctrlEx.memToReg;
        exMem.regWrite      = ctrlEx.regWrite;
        exMem.halt          = ctrlEx.halt;
    end
endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [cpuPkg::dataWidth-1:0] target,
    input  logic                         halted,
    memBusIf.requester                   bus,
    output cpuPkg::ifIdT                 ifId
);
    import cpuPkg::*;

    logic [dataWidth-1:0] pc;

    assign bus.req   = !halted;
    assign bus.addr  = pc;
    assign bus.wdata = '0;
    assign bus.we    = 1'b0;

    // A denied fetch leaves a bubble behind.
    assign ifId = '{pc: pc, instr: bus.rdata, valid: bus.gnt};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (bus.gnt && !stall) begin
            pc <= pc + 1'b1;
        end
    end
endmodule

`default_nettype wire

/* idexReg.sv */
`timescale 1ns/100ps
`default_nettype none

module idexReg (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::dataWidth-1:0]    pc,
    input  logic [cpuPkg::dataWidth-1:0]    read1,
    input  logic [cpuPkg::dataWidth-1:0]    read2,
    input  logic [cpuPkg::dataWidth-1:0]    imm,
    input  logic [cpuPkg::dataWidth-1:0]    jumpDist,
    input  cpuPkg::functT                   funct,
    input  cpuPkg::aluOpT                   aluOp,
    input  logic [cpuPkg::regAddrWidth-1:0] writeReg,
    input  logic [cpuPkg::regAddrWidth-1:0] rs,
    input  logic [cpuPkg::regAddrWidth-1:0] rt,
    input  logic                            rsValid,
    input  logic                            rtValid,
    input  logic                            writeRegValid,
    input  cpuPkg::ctrlT                    ctrl,
    input  logic                            controlZeroIdEx1,
    input  logic                            controlZeroIdEx2,
    output logic [cpuPkg::dataWidth-1:0]    pcEx,
    output logic [cpuPkg::dataWidth-1:0]    read1Ex,
    output logic [cpuPkg::dataWidth-1:0]    read2Ex,
    output logic [cpuPkg::dataWidth-1:0]    immEx,
    output logic [cpuPkg::dataWidth-1:0]    jumpDistEx,
    output cpuPkg::functT                   functEx,
    output cpuPkg::aluOpT                   aluOpEx,
    output logic [cpuPkg::regAddrWidth-1:0] writeRegEx,
    output logic [cpuPkg::regAddrWidth-1:0] rsEx,
    output logic [cpuPkg::regAddrWidth-1:0] rtEx,
    output logic                            rsValidEx,
    output logic                            rtValidEx,
    output logic                            writeRegValidEx,
    output cpuPkg::ctrlT                    ctrlEx
);

    logic squash;

    assign squash = controlZeroIdEx1 | controlZeroIdEx2;

    always_ff @(posedge clk) begin
        pcEx       <= pc;
        read1Ex    <= read1;
        read2Ex    <= read2;
        immEx      <= imm;
        jumpDistEx <= jumpDist;
        functEx    <= funct;
        aluOpEx    <= aluOp;
        writeRegEx <= writeReg;
        rsEx       <= rs;
        rtEx       <= rt;
    end

    // A squashed slot loses its writes, halt, branch and jump.
    always_ff @(posedge clk) begin
        if (!rstN || squash) begin
            ctrlEx          <= '0;
            rsValidEx       <= 1'b0;
            rtValidEx       <= 1'b0;
            writeRegValidEx <= 1'b0;
        end else begin
            ctrlEx          <= ctrl;
            rsValidEx       <= rsValid;
            rtValidEx       <= rtValid;
            writeRegValidEx <= writeRegValid;
        end
    end
endmodule

`default_nettype wire

/* memArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module memArbiter (
    input  logic                         clk,
    input  logic                         rstN,
    memBusIf.arbiter                     fetchBus,
    memBusIf.arbiter                     dataBus,
    output logic                         memEn,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWdata,
    output logic                         memWe,
    input  logic [cpuPkg::dataWidth-1:0] memRdata
);

    // Data side always wins.
    assign dataBus.gnt  = dataBus.req;
    assign fetchBus.gnt = fetchBus.req && !dataBus.req;

    assign memEn    = dataBus.req || fetchBus.req;
    assign memAddr  = dataBus.req ? dataBus.addr : fetchBus.addr;
    assign memWdata = dataBus.req ? dataBus.wdata : fetchBus.wdata;
    assign memWe    = dataBus.req ? dataBus.we : fetchBus.we;

    assign dataBus.rdata  = memRdata;
    assign fetchBus.rdata = memRdata;
endmodule

`default_nettype wire

/* memBusIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface memBusIf;
    import cpuPkg::*;

    logic                 req;
    logic                 gnt;
    logic                 we;
    logic [dataWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic [dataWidth-1:0] rdata;  // Valid in the cycle gnt is high.

    modport requester (
        output req, addr, wdata, we,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, addr, wdata, we,
        output gnt, rdata
    );
endinterface

`default_nettype wire

/* memWbStage.sv */
`timescale 1ns/100ps
`default_nettype none

module memWbStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  cpuPkg::exMemT                   exMem,
    memBusIf.requester                      bus,
    output logic                            wbEn,
    output logic [cpuPkg::regAddrWidth-1:0] wbReg,
    output logic [cpuPkg::dataWidth-1:0]    wbData,
    output logic                            halt
);

    logic haltQ;

    // Nothing after HALT touches memory or registers.
    assign bus.req   = (exMem.memRead || exMem.memWrite) && !haltQ;
    assign bus.addr  = exMem.aluResult;
    assign bus.wdata = exMem.storeData;
    assign bus.we    = exMem.memWrite && !haltQ;

    assign wbEn   = exMem.regWrite && !haltQ && (!exMem.memRead || bus.gnt);
    assign wbReg  = exMem.writeReg;
    assign wbData = exMem.memToReg ? bus.rdata : exMem.aluResult;
    assign halt   = haltQ || exMem.halt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            haltQ <= 1'b0;
        end else if (exMem.halt) begin
            haltQ <= 1'b1;
        end
    end
endmodule

`default_nettype wire

/* pipeReg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    en,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;  // Bubble.
        end else if (en) begin
            q <= d;
        end
    end
endmodule

`default_nettype wire
